//--- tests/emu_golden.txt
# opcode then values, words in hex, counts in decimal
# RAMW/RAMR: 16 scan words; FFR/FFW: word1 word0; RUN/PAUSE: cycles; STAT: up down
# state after reset
STAT 0 1
FFR 0 0
FFR 0 0
# ram write scan then read back
RAMW 1 2 3 4 5 6 7 8 9 a b c d e f 10
RAMR 1 2 3 4 5 6 7 8 9 a b c d e f 10
# run 20 target cycles, pointer wraps once
UP
STAT 1 0
RUN 20
FFR 1404 9c
RAMR 89 8c 92 9c f 15 1c 24 2d 37 42 4e 5b 69 78 88
# paused state holds
PAUSE 50
FFR 1404 9c
# load cycles 100, ptr e, acc 1000 then run 3 cycles
FFW 1000e 1000
RUN 3
FFR 10301 1189
# one more target cycle while draining down
DOWN
STAT 0 1
FFR 10402 1215
RAMR 1189 1215 92 9c f 15 1c 24 2d 37 42 4e 5b 69 1078 1100

//--- filelist.f
verilog/emu_pkg.sv
verilog/clock_gate.sv
verilog/emu_clock_ctrl.sv
verilog/target_core.sv
verilog/emu_mem_model.sv
verilog/emu_top.sv
tests/emu_top_tb.sv

//--- tests/emu_top_tb.sv
`timescale 1ns/1ps

module emu_top_tb;

    localparam int RAM_DEPTH    = 16;
    localparam int MEM_LATENCY  = 2;
    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 16;

    logic                   clk;
    logic                   rst_n;
    logic                   pause;
    logic                   up_req;
    logic                   down_req;
    emu_pkg::emu_ctrl_t     ctrl;
    emu_pkg::scan_word_t    ff_sdi;
    emu_pkg::scan_word_t    ram_sdi;
    emu_pkg::scan_word_t    ff_sdo;
    emu_pkg::scan_word_t    ram_sdo;
    logic                   up;
    logic                   down;

    emu_pkg::scan_word_t    ram_words [RAM_DEPTH];
    longint                 watchdog_ns = 0;
    int                     fd;

    emu_top #(
        .RAM_DEPTH   (RAM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .pause    (pause),
        .ctrl     (ctrl),
        .ff_sdi   (ff_sdi),
        .ram_sdi  (ram_sdi),
        .up_req   (up_req),
        .down_req (down_req),
        .ff_sdo   (ff_sdo),
        .ram_sdo  (ram_sdo),
        .up       (up),
        .down     (down)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH at %0t: %s expected %h got %h",
                               $time, name, expected, actual));
        end
    endtask

    // inputs change shortly after the rising edge
    task automatic next_cycle;
        @(posedge clk);
        #0.5;
    endtask

    task automatic read_word(output emu_pkg::scan_word_t word);
        int n;
        n = $fscanf(fd, "%h", word);
        if (n != 1) begin
            fail_run("golden file ended in the middle of a command");
        end
    endtask

    task automatic read_count(output int value);
        int n;
        n = $fscanf(fd, "%d", value);
        if (n != 1) begin
            fail_run("golden file has a command without its count");
        end
    endtask

    // word 1 leaves the chain first, then word 0
    task automatic ff_scan_words(input logic dir, input emu_pkg::scan_word_t word1,
                                 input emu_pkg::scan_word_t word0);
        emu_pkg::scan_word_t words [emu_pkg::FF_CHAIN_WORDS];
        words[0] = word1;
        words[1] = word0;
        for (int i = 0; i < emu_pkg::FF_CHAIN_WORDS; i++) begin
            ctrl.ff_scan = 1'b1;
            ctrl.ff_dir  = dir;
            ff_sdi       = dir ? words[i] : '0;
            if (!dir) begin
                check_value("ff_sdo", words[i], ff_sdo);
            end
            next_cycle();
        end
        ctrl.ff_scan = 1'b0;
        ctrl.ff_dir  = 1'b0;
        ff_sdi       = '0;
        next_cycle();
    endtask

    task automatic ram_scan_words(input logic dir);
        for (int i = 0; i < RAM_DEPTH; i++) begin
            ctrl.ram_scan = 1'b1;
            ctrl.ram_dir  = dir;
            ram_sdi       = dir ? ram_words[i] : '0;
            if (!dir) begin
                check_value($sformatf("ram_sdo[%0d]", i), ram_words[i], ram_sdo);
            end
            next_cycle();
        end
        // low scan edge clears the scan pointer
        ctrl.ram_scan = 1'b0;
        ctrl.ram_dir  = 1'b0;
        ram_sdi       = '0;
        next_cycle();
    endtask

    task automatic raise_up;
        up_req = 1'b1;
        next_cycle();
        up_req = 1'b0;
        check_value("up", 1, up);
    endtask

    // each target cycle is one fire edge plus the memory latency
    task automatic run_target(input int cycles);
        pause = 1'b0;
        repeat (cycles * (1 + MEM_LATENCY)) next_cycle();
        pause = 1'b1;
    endtask

    task automatic drain_down;
        int waited;
        waited = 0;
        pause  = 1'b0;
        // fire edge, the stall starts here
        next_cycle();
        down_req = 1'b1;
        next_cycle();
        down_req = 1'b0;
        check_value("down", 0, down);
        while (!down && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (!down) begin
            fail_run("down never rose after the drain request");
        end
        check_value("drain cycles", MEM_LATENCY, waited);
        // target stays stopped in st_down even with pause low
        repeat (10) next_cycle();
        pause = 1'b1;
    endtask

    task automatic count_commands(output int lines, output int run_total);
        reg [8*8-1:0]   op;
        reg [8*256-1:0] rest;
        int             n;
        int             value;
        lines     = 0;
        run_total = 0;
        fd = $fopen("tests/emu_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tests/emu_golden.txt");
        end
        n = $fscanf(fd, "%s", op);
        while (n == 1) begin
            if (op == "RUN") begin
                read_count(value);
                run_total += value;
            end else begin
                n = $fgets(rest, fd);
            end
            if (op != "#") begin
                lines++;
            end
            n = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
    endtask

    task automatic execute_commands;
        reg [8*8-1:0]           op;
        reg [8*256-1:0]         rest;
        int                     n;
        int                     a;
        int                     b;
        emu_pkg::scan_word_t    w0;
        emu_pkg::scan_word_t    w1;
        fd = $fopen("tests/emu_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tests/emu_golden.txt");
        end
        n = $fscanf(fd, "%s", op);
        while (n == 1) begin
            case (op)
                "#": n = $fgets(rest, fd);
                "RAMW", "RAMR": begin
                    for (int i = 0; i < RAM_DEPTH; i++) begin
                        read_word(w0);
                        ram_words[i] = w0;
                    end
                    ram_scan_words(op == "RAMW");
                end
                "FFR", "FFW": begin
                    read_word(w1);
                    read_word(w0);
                    ff_scan_words(op == "FFW", w1, w0);
                end
                "UP": raise_up();
                "RUN": begin
                    read_count(a);
                    run_target(a);
                end
                "PAUSE": begin
                    read_count(a);
                    pause = 1'b1;
                    repeat (a) next_cycle();
                end
                "DOWN": drain_down();
                "STAT": begin
                    read_count(a);
                    read_count(b);
                    check_value("up", a, up);
                    check_value("down", b, down);
                end
                default: fail_run($sformatf("unknown golden command %0s", op));
            endcase
            n = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
    endtask

    initial begin
        int cmd_lines;
        int run_total;
        clk      = 1'b0;
        rst_n    = 1'b0;
        pause    = 1'b1;
        up_req   = 1'b0;
        down_req = 1'b0;
        ctrl     = '0;
        ff_sdi   = '0;
        ram_sdi  = '0;
        count_commands(cmd_lines, run_total);
        watchdog_ns = longint'(run_total * (1 + MEM_LATENCY) + 200 * cmd_lines
                               + RESET_CYCLES) * CLK_NS;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        next_cycle();
        execute_commands();
        $display("All tests passed!");
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        fail_run($sformatf("timeout: the run did not finish within %0d ns", watchdog_ns));
    end

endmodule

//--- verilog/emu_top.sv
`timescale 1ns/1ps

module emu_top #(
    parameter int RAM_DEPTH   = 16,
    parameter int MEM_LATENCY = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pause,
    input  emu_pkg::emu_ctrl_t  ctrl,
    input  emu_pkg::scan_word_t ff_sdi,
    input  emu_pkg::scan_word_t ram_sdi,
    input  logic                up_req,
    input  logic                down_req,
    output emu_pkg::scan_word_t ff_sdo,
    output emu_pkg::scan_word_t ram_sdo,
    output logic                up,
    output logic                down
);

    logic                           fire;
    logic                           stall;
    logic                           ff_clk_en;
    logic                           ram_clk_en;
    logic                           ff_clk;
    logic                           ram_clk;
    emu_pkg::scan_word_t            ff_scan_in;
    emu_pkg::scan_word_t            mem_rdata;
    emu_pkg::scan_word_t            mem_wdata;
    logic [$clog2(RAM_DEPTH)-1:0]   mem_ptr;

    emu_clock_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .pause      (pause),
        .ctrl       (ctrl),
        .stall      (stall),
        .up_req     (up_req),
        .down_req   (down_req),
        .fire       (fire),
        .ff_clk_en  (ff_clk_en),
        .ram_clk_en (ram_clk_en),
        .up         (up),
        .down       (down)
    );

    clock_gate u_dut_ff_gate (
        .clk  (clk),
        .en   (ff_clk_en),
        .gclk (ff_clk)
    );

    clock_gate u_dut_ram_gate (
        .clk  (clk),
        .en   (ram_clk_en),
        .gclk (ram_clk)
    );

    emu_mem_model #(
        .RAM_DEPTH   (RAM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk        (clk),
        .ram_clk    (ram_clk),
        .rst_n      (rst_n),
        .fire       (fire),
        .up         (up),
        .ctrl       (ctrl),
        .ram_sdi    (ram_sdi),
        .ff_sdi     (ff_sdi),
        .ff_sdo     (ff_sdo),
        .mem_ptr    (mem_ptr),
        .mem_wdata  (mem_wdata),
        .ff_scan_in (ff_scan_in),
        .ram_sdo    (ram_sdo),
        .mem_rdata  (mem_rdata),
        .stall      (stall)
    );

    target_core #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_core (
        .ff_clk    (ff_clk),
        .rst_n     (rst_n),
        .fire      (fire),
        .ff_scan   (ctrl.ff_scan),
        .scan_in   (ff_scan_in),
        .mem_rdata (mem_rdata),
        .scan_out  (ff_sdo),
        .mem_ptr   (mem_ptr),
        .mem_wdata (mem_wdata)
    );

endmodule

//--- verilog/emu_mem_model.sv
`timescale 1ns/1ps

module emu_mem_model #(
    parameter int RAM_DEPTH   = 16,
    parameter int MEM_LATENCY = 2
) (
    input  logic                            clk,
    input  logic                            ram_clk,
    input  logic                            rst_n,
    input  logic                            fire,
    input  logic                            up,
    input  emu_pkg::emu_ctrl_t              ctrl,
    input  emu_pkg::scan_word_t             ram_sdi,
    input  emu_pkg::scan_word_t             ff_sdi,
    input  emu_pkg::scan_word_t             ff_sdo,
    input  logic [$clog2(RAM_DEPTH)-1:0]    mem_ptr,
    input  emu_pkg::scan_word_t             mem_wdata,
    output emu_pkg::scan_word_t             ff_scan_in,
    output emu_pkg::scan_word_t             ram_sdo,
    output emu_pkg::scan_word_t             mem_rdata,
    output logic                            stall
);

    localparam int PTR_W = $clog2(RAM_DEPTH);
    localparam int LAT_W = $clog2(MEM_LATENCY + 1);

    typedef logic [PTR_W-1:0] ram_ptr_t;
    typedef logic [LAT_W-1:0] lat_cnt_t;

    emu_pkg::scan_word_t    ram [RAM_DEPTH];
    ram_ptr_t               scan_ptr;
    ram_ptr_t               waddr;
    emu_pkg::scan_word_t    wdata;
    logic                   we;
    lat_cnt_t               lat_cnt;
    logic                   scan_q;
    logic                   rd_load;

    // read scan loops the chain back onto itself
    assign ff_scan_in = ctrl.ff_dir ? ff_sdi : ff_sdo;

    // single write port, scan has priority over target write-back
    always_comb begin
        if (ctrl.ram_scan) begin
            we    = ctrl.ram_dir;
            waddr = scan_ptr;
            wdata = ram_sdi;
        end else begin
            we    = fire;
            waddr = mem_ptr;
            wdata = mem_wdata;
        end
    end

    always_ff @(posedge ram_clk) begin
        if (we) begin
            ram[waddr] <= wdata;
        end
    end

    assign ram_sdo = ram[scan_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n || !ctrl.ram_scan) begin
            scan_ptr <= '0;
        end else begin
            scan_ptr <= scan_ptr + 1'b1;
        end
    end

    // latency counter, loaded on each fire edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lat_cnt <= '0;
            scan_q  <= 1'b0;
        end else begin
            scan_q <= ctrl.ff_scan || ctrl.ram_scan;
            if (fire) begin
                lat_cnt <= lat_cnt_t'(MEM_LATENCY);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    // one extra cycle after a scan lets the read port see the moved pointer
    assign stall = (lat_cnt != '0) || scan_q;

    // while down the read port follows the pointer, so it is preloaded on up
    assign rd_load = !fire && ((lat_cnt <= lat_cnt_t'(1)) || !up);

    always_ff @(posedge clk) begin
        if (rd_load) begin
            mem_rdata <= ram[mem_ptr];
        end
    end

endmodule

//--- verilog/target_core.sv
`timescale 1ns/1ps

module target_core #(
    parameter int RAM_DEPTH = 16
) (
    input  logic                            ff_clk,
    input  logic                            rst_n,
    input  logic                            fire,
    input  logic                            ff_scan,
    input  emu_pkg::scan_word_t             scan_in,
    input  emu_pkg::scan_word_t             mem_rdata,
    output emu_pkg::scan_word_t             scan_out,
    output logic [$clog2(RAM_DEPTH)-1:0]    mem_ptr,
    output emu_pkg::scan_word_t             mem_wdata
);

    localparam int PTR_W = $clog2(RAM_DEPTH);

    typedef logic [PTR_W-1:0] ram_ptr_t;

    // word 0 is acc, word 1 is {cycles, ptr}
    emu_pkg::scan_word_t chain [emu_pkg::FF_CHAIN_WORDS];

    emu_pkg::scan_word_t    acc;
    emu_pkg::cycle_count_t  cycles;
    emu_pkg::cycle_count_t  cycles_next;
    ram_ptr_t               ptr;
    ram_ptr_t               ptr_next;

    assign acc    = chain[0];
    assign cycles = chain[1][emu_pkg::SCAN_W-1 -: emu_pkg::CYCLE_W];
    assign ptr    = chain[1][PTR_W-1:0];

    // accumulate and advance, pointer wraps at the power of two depth
    assign mem_wdata   = acc + mem_rdata;
    assign ptr_next    = ptr + 1'b1;
    assign cycles_next = cycles + 1'b1;

    assign mem_ptr  = ptr;
    assign scan_out = chain[emu_pkg::FF_CHAIN_WORDS-1];

    always_ff @(posedge ff_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < emu_pkg::FF_CHAIN_WORDS; i++) begin
                chain[i] <= '0;
            end
        end else if (ff_scan) begin
            chain[0] <= scan_in;
            for (int i = 1; i < emu_pkg::FF_CHAIN_WORDS; i++) begin
                chain[i] <= chain[i-1];
            end
        end else if (fire) begin
            chain[0] <= mem_wdata;
            chain[1] <= {cycles_next, emu_pkg::ptr_field_t'(ptr_next)};
        end
    end

endmodule

//--- verilog/emu_clock_ctrl.sv
`timescale 1ns/1ps

module emu_clock_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pause,
    input  emu_pkg::emu_ctrl_t  ctrl,
    input  logic                stall,
    input  logic                up_req,
    input  logic                down_req,
    output logic                fire,
    output logic                ff_clk_en,
    output logic                ram_clk_en,
    output logic                up,
    output logic                down
);

    emu_pkg::run_state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= emu_pkg::st_down;
        end else begin
            case (state)
                emu_pkg::st_down: begin
                    if (up_req) begin
                        state <= emu_pkg::st_up;
                    end
                end
                emu_pkg::st_up: begin
                    if (down_req) begin
                        state <= emu_pkg::st_draining;
                    end
                end
                // let the outstanding memory read finish first
                emu_pkg::st_draining: begin
                    if (!stall) begin
                        state <= emu_pkg::st_down;
                    end
                end
                default: begin
                    state <= emu_pkg::st_down;
                end
            endcase
        end
    end

    assign up   = (state == emu_pkg::st_up);
    assign down = (state == emu_pkg::st_down);

    // one target cycle
    assign fire = up && !pause && !stall;

    // scan edges bypass the fire condition
    // ff domain also clocks during reset so the core registers clear
    assign ff_clk_en  = fire || ctrl.ff_scan || !rst_n;
    assign ram_clk_en = fire || ctrl.ram_scan;

endmodule

//--- verilog/clock_gate.sv
`timescale 1ns/1ps

module clock_gate (
    input  logic clk,
    input  logic en,
    output logic gclk
);

    logic en_latched;

    // enable may only change while clk is low
    always_latch begin
        if (!clk) begin
            en_latched <= en;
        end
    end

    assign gclk = clk & en_latched;

endmodule

//--- verilog/emu_pkg.sv
package emu_pkg;

    // scan and ram word width
    localparam int SCAN_W = 64;

    // target cycle counter width, upper part of ff scan word 1
    localparam int CYCLE_W = 56;

    // low part of ff scan word 1 holding the ram pointer
    localparam int PTR_FIELD_W = SCAN_W - CYCLE_W;

    // number of words in the ff scan chain
    localparam int FF_CHAIN_WORDS = 2;

    typedef logic [SCAN_W-1:0] scan_word_t;
    typedef logic [CYCLE_W-1:0] cycle_count_t;
    typedef logic [PTR_FIELD_W-1:0] ptr_field_t;

    // host scan controls
    typedef struct packed {
        logic ff_scan;
        logic ff_dir;
        logic ram_scan;
        logic ram_dir;
    } emu_ctrl_t;

    typedef enum logic [1:0] {
        st_down     = 2'd0,
        st_up       = 2'd1,
        st_draining = 2'd2
    } run_state_t;

endpackage
